//--- Makefile
VERILATOR  ?= verilator
TOP        := hart_ctrl_tb
FILELIST   := hart_ctrl.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/hart_ctrl_sva.sv
/*
 * Concurrent checks on the hart_ctrl status outputs
 * and the bind into the top level
 */

module hart_ctrl_sva import hart_ctrl_pkg::*; (
  input logic        clk_i,
  input logic        rst_i,
  input hart_state_e state_i,
  input logic        irq_ack_i,
  input logic        running_i,
  input logic        halted_i,
  input logic        sleep_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Halted and running are exclusive
  halt_run_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(halted_i && running_i))
    else $error("halted and running are high together");

  // Acknowledge only from an awake, running hart
  ack_when_running: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_ack_i |-> (running_i && !sleep_i && state_i == RUNNING))
    else $error("interrupt acknowledge outside the running state");

  // Trap entry clears MIE so the strobe drops
  ack_single_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_ack_i |=> !irq_ack_i)
    else $error("interrupt acknowledge lasted two cycles");

  sleep_halt_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(sleep_i && halted_i))
    else $error("sleep and halted are high together");

endmodule

bind hart_ctrl hart_ctrl_sva sva_i (
  .clk_i     ( clk_i             ),
  .rst_i     ( rst_i             ),
  .state_i   ( hart_state        ),
  .irq_ack_i ( irq_ack_o         ),
  .running_i ( debug_running_o   ),
  .halted_i  ( debug_halted_o    ),
  .sleep_i   ( core_sleep_o      )
);

//--- bench/hart_ctrl_tb.sv
/*
 * Table-driven testbench for hart_ctrl covering boot, CSR access, interrupts,
 * WFI and debug halt, with an LFSR, a reference model and a timeout
 */

module hart_ctrl_tb import hart_csr_pkg::*, hart_ctrl_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum {OP_BOOT, OP_CSR_WRITE, OP_CSR_READ, OP_MCYCLE,
                OP_IRQ, OP_IRQ_MASKED, OP_WFI, OP_DEBUG} op_e;
  typedef enum {ST_RUNNING, ST_SLEEP, ST_HALTED} status_e;
  typedef enum {STB_WFI, STB_MRET, STB_DRET, STB_DEBUG} strobe_e;

  // One table row with its share of the timeout budget
  typedef struct {
    op_e       op;
    string     name;
    csr_addr_t addr;
    csr_data_t data;
    csr_data_t irq_mask;
    csr_data_t expected;
    int        budget;
  } row_t;

  localparam int TIMEOUT_MARGIN = 50;

  logic               clk;
  logic               rst;
  logic               fetch_enable;
  logic               debug_req;
  logic [NUM_IRQ-1:0] irq;
  logic               csr_we;
  csr_addr_t          csr_addr;
  csr_data_t          csr_wdata;
  csr_data_t          csr_rdata;
  logic               wfi;
  logic               mret;
  logic               dret;
  logic               irq_ack;
  irq_id_t            irq_id;
  logic               havereset;
  logic               running;
  logic               halted;
  logic               core_sleep;
  logic [63:0]        mcycle;

  row_t        tests[$];
  logic [31:0] lfsr_state = 32'he581_190b;
  int          cyc = 0;
  int          ack_count = 0;
  int          timeout_limit = 0;

  // Reference model of the CSR state
  csr_data_t model_mie;
  csr_data_t model_mcause;
  logic      model_mie_bit;
  logic      model_mpie;

  tb_clk_gen clk_gen (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  hart_ctrl dut_i (
    .clk_i             ( clk          ),
    .rst_i             ( rst          ),
    .fetch_enable_i    ( fetch_enable ),
    .debug_req_i       ( debug_req    ),
    .irq_i             ( irq          ),
    .csr_we_i          ( csr_we       ),
    .csr_addr_i        ( csr_addr     ),
    .csr_wdata_i       ( csr_wdata    ),
    .csr_rdata_o       ( csr_rdata    ),
    .wfi_i             ( wfi          ),
    .mret_i            ( mret         ),
    .dret_i            ( dret         ),
    .irq_ack_o         ( irq_ack      ),
    .irq_id_o          ( irq_id       ),
    .debug_havereset_o ( havereset    ),
    .debug_running_o   ( running      ),
    .debug_halted_o    ( halted       ),
    .core_sleep_o      ( core_sleep   ),
    .mcycle_o          ( mcycle       )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Checks, LFSR and helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_stop();
    $display("Test failures found");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_true(string name, bit cond, string what);
    assert (cond) else begin
      $display("%s: %s", name, what);
      fail_stop();
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic csr_data_t take_bits(int n);
    csr_data_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Highest set line searched from the top
  function automatic int top_line(csr_data_t v);
    for (int i = NUM_IRQ - 1; i >= 0; i--) begin
      if (v[i]) return i;
    end
    return -1;
  endfunction

  function automatic csr_data_t mstatus_model();
    csr_data_t v;
    v = '0;
    v[MSTATUS_MIE_BIT]  = model_mie_bit;
    v[MSTATUS_MPIE_BIT] = model_mpie;
    return v;
  endfunction

  function automatic bit status_is(status_e s);
    case (s)
      ST_RUNNING: return running && !core_sleep && !halted;
      ST_SLEEP:   return core_sleep;
      default:    return halted;
    endcase
  endfunction

  task automatic add_row(op_e op, string name, csr_addr_t addr, csr_data_t data,
                         csr_data_t irq_mask, csr_data_t expected, int budget);
    row_t r;
    r = '{op, name, addr, data, irq_mask, expected, budget};
    tests.push_back(r);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus-level drivers
  ////////////////////////////////////////////////////////////////////////////

  // Write is taken at the second edge and the model follows
  task automatic csr_write(csr_addr_t a, csr_data_t d);
    @(posedge clk);
    csr_we    <= 1'b1;
    csr_addr  <= a;
    csr_wdata <= d;
    @(posedge clk);
    csr_we <= 1'b0;
    if (a == CSR_MSTATUS) begin
      model_mie_bit = d[MSTATUS_MIE_BIT];
      model_mpie    = d[MSTATUS_MPIE_BIT];
    end
    if (a == CSR_MIE) begin
      model_mie = d & MIE_WRITE_MASK;
    end
  endtask

  // Combinational read sampled mid-cycle
  task automatic csr_read(csr_addr_t a, output csr_data_t d);
    @(posedge clk);
    csr_addr <= a;
    @(negedge clk);
    d = csr_rdata;
  endtask

  task automatic pulse(strobe_e s);
    @(posedge clk);
    case (s)
      STB_WFI:  wfi <= 1'b1;
      STB_MRET: mret <= 1'b1;
      STB_DRET: dret <= 1'b1;
      default:  debug_req <= 1'b1;
    endcase
    @(posedge clk);
    wfi       <= 1'b0;
    mret      <= 1'b0;
    dret      <= 1'b0;
    debug_req <= 1'b0;
  endtask

  task automatic idle(int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_status(status_e s, int limit, string name);
    bit seen;
    seen = 0;
    for (int n = 0; n < limit && !seen; n++) begin
      @(negedge clk);
      seen = status_is(s);
    end
    check_true(name, seen, "hart status did not change within the wait limit");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Row execution
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_row(row_t r);
    csr_data_t v;
    csr_data_t a;
    csr_data_t en;
    csr_data_t pend;
    csr_data_t mc_min;
    csr_data_t mc_max;
    int        id;
    int        acks0;
    int        t0;
    bit        seen;
    case (r.op)
      OP_BOOT: begin
        check_value({r.name, " havereset"}, 1, havereset);
        check_value({r.name, " running"}, 0, running);
        check_value({r.name, " mcycle"}, 0, mcycle);
        @(posedge clk);
        fetch_enable <= 1'b1;
        wait_status(ST_RUNNING, 3, r.name);
        check_value({r.name, " havereset after boot"}, 0, havereset);
        a = mcycle[31:0];
        idle(3);
        check_true(r.name, mcycle[31:0] > a, "mcycle did not start counting");
      end
      OP_CSR_WRITE: begin
        csr_write(r.addr, r.data);
        csr_read(r.addr, v);
        check_value(r.name, r.expected, v);
      end
      OP_CSR_READ: begin
        csr_read(r.addr, v);
        check_value(r.name, r.expected, v);
      end
      OP_MCYCLE: begin
        csr_write(CSR_MCYCLEH, r.expected);
        csr_write(CSR_MCYCLE, r.data);
        @(negedge clk);
        t0 = cyc;
        idle(4);
        csr_read(CSR_MCYCLE, v);
        // Low half lies between the written value and one step per edge
        mc_min = r.data;
        mc_max = r.data + csr_data_t'(cyc - t0);
        check_true(r.name, v >= mc_min && v <= mc_max, "mcycle outside its window");
        csr_read(CSR_MCYCLEH, v);
        check_value({r.name, " high"}, r.expected, v);
      end
      OP_IRQ, OP_IRQ_MASKED: begin
        // Random enables and lines with at least one enabled line pending
        en = take_bits(32) & r.irq_mask;
        if (en == '0) en = r.irq_mask & (~r.irq_mask + 32'd1);
        pend = take_bits(32);
        if ((pend & en) == '0) pend = pend | (en & (~en + 32'd1));
        csr_write(CSR_MIE, en);
        id = top_line(pend & model_mie);
        csr_write(CSR_MSTATUS, (r.op == OP_IRQ) ? 32'h0000_0008 : 32'h0);
        @(posedge clk);
        irq <= pend;
        @(negedge clk);
        acks0 = ack_count;
        if (r.op == OP_IRQ_MASKED) begin
          idle(8);
          check_value({r.name, " acks"}, acks0, ack_count);
          csr_read(CSR_MIP, v);
          check_value({r.name, " mip"}, pend, v);
        end else begin
          seen = 0;
          for (int n = 0; n < 8 && !seen; n++) begin
            @(negedge clk);
            seen = irq_ack;
          end
          check_true(r.name, seen, "no interrupt acknowledge");
          check_value({r.name, " id"}, id, irq_id);
          idle(4);
          check_value({r.name, " acks"}, acks0 + 1, ack_count);
          // Trap entry in the model
          model_mpie    = model_mie_bit;
          model_mie_bit = 1'b0;
          model_mcause  = 32'h8000_0000 | csr_data_t'(id);
          csr_read(CSR_MCAUSE, v);
          check_value({r.name, " mcause"}, model_mcause, v);
          csr_read(CSR_MSTATUS, v);
          check_value({r.name, " mstatus trap"}, mstatus_model(), v);
          // Lines quiet before mret
          @(posedge clk);
          irq <= '0;
          pulse(STB_MRET);
          model_mie_bit = model_mpie;
          model_mpie    = 1'b1;
          csr_read(CSR_MSTATUS, v);
          check_value({r.name, " mstatus mret"}, mstatus_model(), v);
        end
        @(posedge clk);
        irq <= '0;
        idle(2);
      end
      OP_WFI: begin
        csr_write(CSR_MSTATUS, 32'h0);
        csr_write(CSR_MIE, 32'h0);
        pulse(STB_WFI);
        wait_status(ST_SLEEP, 4, r.name);
        csr_read(CSR_MCYCLE, a);
        idle(3);
        csr_read(CSR_MCYCLE, v);
        check_value({r.name, " frozen mcycle"}, a, v);
        acks0 = ack_count;
        // Wake-up with MIE still clear
        csr_write(CSR_MIE, r.irq_mask);
        @(posedge clk);
        irq <= r.irq_mask;
        wait_status(ST_RUNNING, 8, r.name);
        idle(2);
        check_value({r.name, " acks"}, acks0, ack_count);
        @(posedge clk);
        irq <= '0;
        idle(2);
      end
      default: begin
        pulse(STB_DEBUG);
        wait_status(ST_HALTED, 4, r.name);
        check_value({r.name, " running"}, 0, running);
        csr_read(CSR_DCSR, v);
        check_value({r.name, " dcsr"}, r.expected, v);
        csr_read(CSR_MCYCLE, a);
        idle(3);
        csr_read(CSR_MCYCLE, v);
        check_value({r.name, " frozen mcycle"}, a, v);
        pulse(STB_DRET);
        wait_status(ST_RUNNING, 4, r.name);
        csr_read(CSR_MCYCLE, a);
        idle(3);
        csr_read(CSR_MCYCLE, v);
        check_true(r.name, v > a, "mcycle did not resume after dret");
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Edge monitor, watchdog and main flow
  ////////////////////////////////////////////////////////////////////////////

  // Counted at the edge and read by the main flow at negedge
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (!rst && irq_ack) begin
      ack_count <= ack_count + 1;
    end
    if (cyc >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      fail_stop();
    end
  end

  initial begin
    fetch_enable <= 1'b0;
    debug_req    <= 1'b0;
    irq          <= '0;
    csr_we       <= 1'b0;
    csr_addr     <= '0;
    csr_wdata    <= '0;
    wfi          <= 1'b0;
    mret         <= 1'b0;
    dret         <= 1'b0;
    model_mie     = '0;
    model_mcause  = '0;
    model_mie_bit = 1'b0;
    model_mpie    = 1'b0;

    add_row(OP_BOOT, "boot", '0, '0, '0, '0, 20);
    add_row(OP_CSR_WRITE, "mie_all", CSR_MIE, 32'hFFFF_FFFF, '0, 32'hFFFF_0888, 8);
    add_row(OP_CSR_WRITE, "mie_mix", CSR_MIE, 32'h1234_5678, '0, 32'h1234_0008, 8);
    add_row(OP_CSR_WRITE, "mstatus_all", CSR_MSTATUS, 32'hFFFF_FFFF, '0, 32'h88, 8);
    add_row(OP_CSR_WRITE, "mstatus_clear", CSR_MSTATUS, 32'h0, '0, 32'h0, 8);
    add_row(OP_CSR_WRITE, "mcause_rw", CSR_MCAUSE, 32'hA5A5_5A5A, '0, 32'hA5A5_5A5A, 8);
    add_row(OP_CSR_READ, "unknown_123", 12'h123, '0, '0, 32'h0, 4);
    add_row(OP_CSR_READ, "unknown_fff", 12'hFFF, '0, '0, 32'h0, 4);
    add_row(OP_CSR_READ, "mip_idle", CSR_MIP, '0, '0, 32'h0, 4);
    add_row(OP_MCYCLE, "mcycle_wr", CSR_MCYCLE, 32'h7000_0000, '0, 32'h1, 20);
    add_row(OP_IRQ, "irq_all", '0, '0, 32'hFFFF_0888, '0, 40);
    add_row(OP_IRQ, "irq_std", '0, '0, 32'h0000_0888, '0, 40);
    add_row(OP_IRQ, "irq_custom", '0, '0, 32'hFFFF_0000, '0, 40);
    add_row(OP_IRQ, "irq_again", '0, '0, 32'hFFFF_0888, '0, 40);
    add_row(OP_IRQ_MASKED, "irq_masked", '0, '0, 32'hFFFF_0888, '0, 30);
    add_row(OP_WFI, "wfi_wake", '0, '0, 32'h0000_0080, '0, 40);
    add_row(OP_DEBUG, "debug_halt", '0, '0, '0, 32'h0000_00C0, 40);

    // Reset cycles plus every row's budget plus margin
    timeout_limit = 5 + TIMEOUT_MARGIN;
    foreach (tests[i]) timeout_limit += tests[i].budget;

    @(negedge clk);
    while (rst) @(negedge clk);
    foreach (tests[i]) run_row(tests[i]);

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- bench/tb_clk_gen.sv
/*
 * Testbench clock with a 4 ns period and a 5-cycle reset pulse
 */

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 5;

  // Free-running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Released on a rising edge like any other input
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- hart_ctrl.f
logic/hart_csr_pkg.sv
logic/hart_ctrl_pkg.sv
logic/hart_ctrl_fsm.sv
logic/mcycle_counter.sv
logic/hart_csr_file.sv
logic/int_controller.sv
logic/hart_ctrl.sv
bench/tb_clk_gen.sv
bench/hart_ctrl_sva.sv
bench/hart_ctrl_tb.sv

//--- logic/hart_csr_file.sv
/*
 * Minimal machine CSR file: mstatus, mie, mip, mcause, dcsr, mcycle(h)
 * Read mux, trap and mret updates, debug cause capture
 */

module hart_csr_file import hart_csr_pkg::*, hart_ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,

  // Software access port
  input  logic        csr_we_i,
  input  csr_addr_t   csr_addr_i,
  input  csr_data_t   csr_wdata_i,
  output csr_data_t   csr_rdata_o,

  // Retirement and FSM events
  input  logic        mret_i,
  input  logic        irq_ack_i,
  input  irq_id_t     irq_id_i,
  input  logic        dbg_entry_i,

  // Interrupt controller side
  input  csr_data_t   mip_i,
  output csr_data_t   mie_o,
  output logic        m_irq_enable_o,

  // Counter side
  input  logic [63:0] mcycle_i,
  output logic        mcycle_wr_lo_o,
  output logic        mcycle_wr_hi_o
);

  logic       mstatus_mie_q;
  logic       mstatus_mpie_q;
  csr_data_t  mie_q;
  csr_data_t  mcause_q;
  logic [2:0] dcsr_cause_q;
  logic       wr_mstatus;
  logic       wr_mie;
  logic       wr_mcause;

  // Write decode
  assign wr_mstatus     = csr_we_i && (csr_addr_i == CSR_MSTATUS);
  assign wr_mie         = csr_we_i && (csr_addr_i == CSR_MIE);
  assign wr_mcause      = csr_we_i && (csr_addr_i == CSR_MCAUSE);
  assign mcycle_wr_lo_o = csr_we_i && (csr_addr_i == CSR_MCYCLE);
  assign mcycle_wr_hi_o = csr_we_i && (csr_addr_i == CSR_MCYCLEH);

  ////////////////////////////////////////////////////////////////////////////
  // Register updates
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mie_q          <= '0;
      mcause_q       <= '0;
      dcsr_cause_q   <= '0;
    end else begin
      // mstatus: trap entry, then mret, then software
      if (irq_ack_i) begin
        mstatus_mpie_q <= mstatus_mie_q;
        mstatus_mie_q  <= 1'b0;
      end else if (mret_i) begin
        mstatus_mie_q  <= mstatus_mpie_q;
        mstatus_mpie_q <= 1'b1;
      end else if (wr_mstatus) begin
        mstatus_mie_q  <= csr_wdata_i[MSTATUS_MIE_BIT];
        mstatus_mpie_q <= csr_wdata_i[MSTATUS_MPIE_BIT];
      end

      // mcause: interrupt flag plus line number
      if (irq_ack_i) begin
        mcause_q                 <= csr_data_t'(irq_id_i);
        mcause_q[MCAUSE_IRQ_BIT] <= 1'b1;
      end else if (wr_mcause) begin
        mcause_q <= csr_wdata_i;
      end

      if (wr_mie) begin
        mie_q <= csr_wdata_i & MIE_WRITE_MASK;
      end

      // Halt cause latched on entry
      if (dbg_entry_i) begin
        dcsr_cause_q <= DBG_CAUSE_HALTREQ;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      CSR_MSTATUS: begin
        csr_rdata_o[MSTATUS_MIE_BIT]  = mstatus_mie_q;
        csr_rdata_o[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
      end
      CSR_MIE:     csr_rdata_o = mie_q;
      CSR_MIP:     csr_rdata_o = mip_i;
      CSR_MCAUSE:  csr_rdata_o = mcause_q;
      CSR_DCSR:    csr_rdata_o[DCSR_CAUSE_LSB +: 3] = dcsr_cause_q;
      CSR_MCYCLE:  csr_rdata_o = mcycle_i[31:0];
      CSR_MCYCLEH: csr_rdata_o = mcycle_i[63:32];
      // Unmapped reads as zero
      default:     csr_rdata_o = '0;
    endcase
  end

  assign mie_o          = mie_q;
  assign m_irq_enable_o = mstatus_mie_q;

endmodule

//--- logic/hart_csr_pkg.sv
/*
 * CSR address map, mstatus and dcsr bit positions, mie write mask
 * and the CSR address and data types
 */

package hart_csr_pkg;

  // Basic CSR widths
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  ////////////////////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;
  localparam csr_addr_t CSR_MIP     = 12'h344;
  localparam csr_addr_t CSR_DCSR    = 12'h7B0;
  localparam csr_addr_t CSR_MCYCLE  = 12'hB00;
  localparam csr_addr_t CSR_MCYCLEH = 12'hB80;

  ////////////////////////////////////////////////////////////////////////////
  // Field positions and masks
  ////////////////////////////////////////////////////////////////////////////

  // Only MIE and MPIE live in mstatus here
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  // MSI, MTI, MEI plus custom lines 16..31
  localparam csr_data_t MIE_WRITE_MASK = 32'hFFFF_0888;

  // Lowest bit of the 3-bit dcsr cause field
  localparam int DCSR_CAUSE_LSB = 6;

endpackage

//--- logic/hart_ctrl.sv
/*
 * Hart control top level
 * FSM, interrupt controller, CSR file and mcycle counter
 */

module hart_ctrl import hart_csr_pkg::*, hart_ctrl_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_i,

  // Hart control
  input  logic               fetch_enable_i,
  input  logic               debug_req_i,
  input  logic [NUM_IRQ-1:0] irq_i,

  // CSR write port and combinational read
  input  logic               csr_we_i,
  input  csr_addr_t          csr_addr_i,
  input  csr_data_t          csr_wdata_i,
  output csr_data_t          csr_rdata_o,

  // Retirement stand-ins
  input  logic               wfi_i,
  input  logic               mret_i,
  input  logic               dret_i,

  output logic               irq_ack_o,
  output irq_id_t            irq_id_o,

  // Debug status
  output logic               debug_havereset_o,
  output logic               debug_running_o,
  output logic               debug_halted_o,

  output logic               core_sleep_o,
  output logic [63:0]        mcycle_o
);

  hart_state_e hart_state;
  logic        irq_req;
  logic        irq_wu;
  logic        dbg_entry;
  logic        count_inhibit;
  logic        m_irq_enable;
  logic        mcycle_wr_lo;
  logic        mcycle_wr_hi;
  csr_data_t   mie;
  csr_data_t   mip;

  ////////////////////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////////////////////

  hart_ctrl_fsm fsm_i (
    .clk_i             ( clk_i             ),
    .rst_i             ( rst_i             ),
    .fetch_enable_i    ( fetch_enable_i    ),
    .debug_req_i       ( debug_req_i       ),
    .wfi_i             ( wfi_i             ),
    .dret_i            ( dret_i            ),
    .irq_req_i         ( irq_req           ),
    .irq_wu_i          ( irq_wu            ),
    .state_o           ( hart_state        ),
    .irq_ack_o         ( irq_ack_o         ),
    .dbg_entry_o       ( dbg_entry         ),
    .count_inhibit_o   ( count_inhibit     ),
    .debug_havereset_o ( debug_havereset_o ),
    .debug_running_o   ( debug_running_o   ),
    .debug_halted_o    ( debug_halted_o    ),
    .core_sleep_o      ( core_sleep_o      )
  );

  // Frozen outside RUNNING instead of clock gating
  mcycle_counter cnt_i (
    .clk_i           ( clk_i         ),
    .rst_i           ( rst_i         ),
    .count_inhibit_i ( count_inhibit ),
    .wr_lo_i         ( mcycle_wr_lo  ),
    .wr_hi_i         ( mcycle_wr_hi  ),
    .wdata_i         ( csr_wdata_i   ),
    .mcycle_o        ( mcycle_o      )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Interrupts and CSRs
  ////////////////////////////////////////////////////////////////////////////

  int_controller irq_i_ctrl (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .irq_i          ( irq_i        ),
    .mie_i          ( mie          ),
    .m_irq_enable_i ( m_irq_enable ),
    .mip_o          ( mip          ),
    .irq_req_o      ( irq_req      ),
    .irq_wu_o       ( irq_wu       ),
    .irq_id_o       ( irq_id_o     )
  );

  hart_csr_file csr_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .csr_we_i       ( csr_we_i       ),
    .csr_addr_i     ( csr_addr_i     ),
    .csr_wdata_i    ( csr_wdata_i    ),
    .csr_rdata_o    ( csr_rdata_o    ),
    .mret_i         ( mret_i         ),
    .irq_ack_i      ( irq_ack_o      ),
    .irq_id_i       ( irq_id_o       ),
    .dbg_entry_i    ( dbg_entry      ),
    .mip_i          ( mip            ),
    .mie_o          ( mie            ),
    .m_irq_enable_o ( m_irq_enable   ),
    .mcycle_i       ( mcycle_o       ),
    .mcycle_wr_lo_o ( mcycle_wr_lo   ),
    .mcycle_wr_hi_o ( mcycle_wr_hi   )
  );

endmodule

//--- logic/hart_ctrl_fsm.sv
/*
 * Hart run control FSM: boot, run, sleep on WFI and debug halt,
 * plus the Mealy interrupt acknowledge and debug entry strobes
 */

module hart_ctrl_fsm import hart_ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,

  // Hart control
  input  logic        fetch_enable_i,
  input  logic        debug_req_i,
  input  logic        wfi_i,
  input  logic        dret_i,

  // From the interrupt controller
  input  logic        irq_req_i,
  input  logic        irq_wu_i,

  output hart_state_e state_o,
  output logic        irq_ack_o,
  output logic        dbg_entry_o,
  output logic        count_inhibit_o,

  // Debug and sleep status
  output logic        debug_havereset_o,
  output logic        debug_running_o,
  output logic        debug_halted_o,
  output logic        core_sleep_o
);

  hart_state_e state_q;
  hart_state_e state_d;
  logic        havereset_q;
  logic        live;

  // Hart is out of boot and not halted
  assign live = (state_q == RUNNING) || (state_q == SLEEP);

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      RESET: begin
        state_d = BOOT_WAIT;
      end
      BOOT_WAIT: begin
        if (fetch_enable_i) begin
          state_d = RUNNING;
        end
      end
      RUNNING: begin
        // Debug first, a taken interrupt beats WFI
        if (debug_req_i) begin
          state_d = DBG_HALTED;
        end else if (wfi_i && !irq_req_i) begin
          state_d = SLEEP;
        end
      end
      SLEEP: begin
        // Wake-up ignores mstatus.MIE
        if (debug_req_i) begin
          state_d = DBG_HALTED;
        end else if (irq_wu_i) begin
          state_d = RUNNING;
        end
      end
      DBG_HALTED: begin
        if (dret_i) begin
          state_d = RUNNING;
        end
      end
      default: begin
        state_d = RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= RESET;
      havereset_q <= 1'b1;
    end else begin
      state_q <= state_d;
      // Dropped on first entry into RUNNING, never set again
      if (state_d == RUNNING) begin
        havereset_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  // Mealy strobes, debug request masks the acknowledge
  assign irq_ack_o   = (state_q == RUNNING) && irq_req_i && !debug_req_i;
  assign dbg_entry_o = live && debug_req_i;

  // mcycle only advances while running
  assign count_inhibit_o = (state_q != RUNNING);

  assign state_o           = state_q;
  assign debug_havereset_o = havereset_q;
  assign debug_running_o   = live;
  assign debug_halted_o    = (state_q == DBG_HALTED);
  assign core_sleep_o      = (state_q == SLEEP);

endmodule

//--- logic/hart_ctrl_pkg.sv
/*
 * Hart state encoding, interrupt id type,
 * debug cause code and mcause interrupt flag
 */

package hart_ctrl_pkg;

  // Hart run control states
  typedef enum logic [2:0] {
    RESET,
    BOOT_WAIT,
    RUNNING,
    SLEEP,
    DBG_HALTED
  } hart_state_e;

  // Machine interrupt lines, one per mie/mip bit
  localparam int NUM_IRQ = 32;

  // Encoded id of the selected line
  typedef logic [4:0] irq_id_t;

  // dcsr cause for an external halt request
  localparam logic [2:0] DBG_CAUSE_HALTREQ = 3'd3;

  // Interrupt flag in mcause
  localparam int MCAUSE_IRQ_BIT = 31;

endpackage

//--- logic/int_controller.sv
/*
 * Machine interrupt controller: mip capture, mie masking,
 * highest-line selection and wake-up
 */

module int_controller import hart_csr_pkg::*, hart_ctrl_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_i,
  // Raw interrupt lines
  input  logic [NUM_IRQ-1:0] irq_i,
  // From the CSR file
  input  csr_data_t          mie_i,
  input  logic               m_irq_enable_i,
  output csr_data_t          mip_o,
  // To the FSM
  output logic               irq_req_o,
  output logic               irq_wu_o,
  output irq_id_t            irq_id_o
);

  csr_data_t mip_q;
  csr_data_t irq_pend;

  // One edge of latency from the pins
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i;
    end
  end

  // Pending and enabled
  assign irq_pend = mip_q & mie_i;

  // Ascending scan, last hit is the highest line
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < NUM_IRQ; i++) begin
      if (irq_pend[i]) begin
        irq_id_o = irq_id_t'(i);
      end
    end
  end

  // Wake-up does not look at mstatus.MIE
  assign irq_wu_o  = |irq_pend;
  assign irq_req_o = irq_wu_o && m_irq_enable_i;

  assign mip_o = mip_q;

endmodule

//--- logic/mcycle_counter.sv
/*
 * 64-bit mcycle counter with inhibit and separate writes
 * to the low and high halves
 */

module mcycle_counter import hart_csr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        count_inhibit_i,
  // Decoded CSR writes to mcycle / mcycleh
  input  logic        wr_lo_i,
  input  logic        wr_hi_i,
  input  csr_data_t   wdata_i,
  output logic [63:0] mcycle_o
);

  logic [63:0] mcycle_q;
  logic [63:0] mcycle_d;
  logic        wr_any;

  assign wr_any = wr_lo_i || wr_hi_i;

  always_comb begin
    mcycle_d = mcycle_q;
    if (wr_any) begin
      // Write replaces its half, no increment this cycle
      if (wr_lo_i) begin
        mcycle_d[31:0] = wdata_i;
      end
      if (wr_hi_i) begin
        mcycle_d[63:32] = wdata_i;
      end
    end else if (!count_inhibit_i) begin
      // Carry ripples into the upper half
      mcycle_d = mcycle_q + 64'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mcycle_q <= '0;
    end else begin
      mcycle_q <= mcycle_d;
    end
  end

  assign mcycle_o = mcycle_q;

endmodule
